/* Makefile */
VERILATOR ?= verilator
TOP       ?= priv_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ALL TESTS PASSED

SRCS := $(filter-out +incdir%,$(shell cat files.f))
HDRS := $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): files.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f files.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
+incdir+include
rtl/priv_pkg.sv
rtl/tlb_array.sv
rtl/csr_file.sv
rtl/priv_exec.sv
rtl/priv_top.sv
test/tb_clock.sv
test/priv_properties.sv
test/priv_tb.sv

/* include/priv_macros.svh */
`ifndef PRIV_MACROS_SVH
`define PRIV_MACROS_SVH

`define PRIV_XLEN   32

// tlb geometry
`define TLB_ENTRIES 8
`define TLB_IDX_W   3
`define ASID_W      10

`define CSR_CRMD    14'h0
`define CSR_PRMD    14'h1
`define CSR_ERA     14'h6
`define CSR_TLBIDX  14'h10
`define CSR_TLBEHI  14'h11
`define CSR_TLBELO0 14'h12
`define CSR_ASID    14'h18

`define FILL_SEED   32'd19260817  // xorshift start value

`endif

/* rtl/csr_file.sv */
`include "priv_macros.svh"

module csr_file (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    csr_query,
    input  logic [13:0]             csr_addr,
    input  logic [`PRIV_XLEN-1:0]   csr_wen,
    input  logic [`PRIV_XLEN-1:0]   csr_wdata,
    input  logic                    restore_state,
    input  logic                    tlb_index_we,
    input  logic                    tlb_e_we,
    input  logic                    tlb_other_we,
    input  logic                    srch_hit,
    input  logic [`TLB_IDX_W-1:0]   srch_idx,
    input  logic [`PRIV_XLEN-1:0]   rd_ehi,
    input  logic [`PRIV_XLEN-1:0]   rd_elo,
    output logic [`PRIV_XLEN-1:0]   csr_rdata,
    output logic [`PRIV_XLEN-1:0]   era,
    output logic [`PRIV_XLEN-1:0]   tlbidx,
    output logic [`PRIV_XLEN-1:0]   tlbehi,
    output logic [`PRIV_XLEN-1:0]   tlbelo0,
    output logic [`ASID_W-1:0]      asid
);
    logic [`PRIV_XLEN-1:0] crmd, prmd, asid_r;

    function automatic logic [`PRIV_XLEN-1:0] merge(input logic [`PRIV_XLEN-1:0] old);
        merge = (old & ~csr_wen) | (csr_wdata & csr_wen);
    endfunction

    assign asid = asid_r[`ASID_W-1:0];

    always_comb begin
        case (csr_addr)
            `CSR_CRMD:    csr_rdata = crmd;
            `CSR_PRMD:    csr_rdata = prmd;
            `CSR_ERA:     csr_rdata = era;
            `CSR_TLBIDX:  csr_rdata = tlbidx;
            `CSR_TLBEHI:  csr_rdata = tlbehi;
            `CSR_TLBELO0: csr_rdata = tlbelo0;
            `CSR_ASID:    csr_rdata = asid_r;
            default:      csr_rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd <= '0;
            prmd <= '0;
            era <= '0;
            tlbidx <= '0;
            tlbehi <= '0;
            tlbelo0 <= '0;
            asid_r <= '0;
        end else begin
            if (csr_query) begin
                case (csr_addr)
                    `CSR_CRMD:    crmd <= merge(crmd);
                    `CSR_PRMD:    prmd <= merge(prmd);
                    `CSR_ERA:     era <= merge(era);
                    `CSR_TLBIDX:  tlbidx <= merge(tlbidx);
                    `CSR_TLBEHI:  tlbehi <= merge(tlbehi);
                    `CSR_TLBELO0: tlbelo0 <= merge(tlbelo0);
                    `CSR_ASID:    asid_r <= merge(asid_r);
                    default:      ;
                endcase
            end
            if (restore_state)
                crmd[2:0] <= prmd[2:0];  // plv and ie back from prmd
            if (tlb_index_we) begin
                tlbidx[31] <= ~srch_hit;  // not-found flag
                if (srch_hit)
                    tlbidx[`TLB_IDX_W-1:0] <= srch_idx;
            end
            if (tlb_e_we)
                tlbehi <= rd_ehi;
            if (tlb_other_we)
                tlbelo0 <= rd_elo;
        end
    end

endmodule

/* rtl/priv_exec.sv */
`include "priv_macros.svh"

module priv_exec (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    en_in,
    input  priv_pkg::priv_op_t      op,
    input  logic [31:0]             inst,
    input  logic [`PRIV_XLEN-1:0]   sr0,
    input  logic [`PRIV_XLEN-1:0]   sr1,
    input  logic [`PRIV_XLEN-1:0]   imm,
    input  logic [`PRIV_XLEN-1:0]   pc_next,
    input  logic [4:0]              addr_in,
    input  logic [`PRIV_XLEN-1:0]   era,
    input  logic [`PRIV_XLEN-1:0]   csr_rdata,
    input  logic                    l1i_ready,
    input  logic                    l1d_ready,
    input  logic                    l2_ready,
    input  logic                    l1i_complete,
    input  logic                    l1d_complete,
    input  logic                    l2_complete,
    input  logic                    icache_idle,
    input  logic                    dcache_idle,
    output logic                    en_out,
    output logic                    flush,
    output logic                    stall,
    output logic [`PRIV_XLEN-1:0]   result,
    output logic [4:0]              addr_out,
    output logic [`PRIV_XLEN-1:0]   pc_target,
    output logic                    csr_query,
    output logic [13:0]             csr_addr,
    output logic [`PRIV_XLEN-1:0]   csr_wen,
    output logic [`PRIV_XLEN-1:0]   csr_wdata,
    output logic                    restore_state,
    output logic                    tlb_index_we,
    output logic                    tlb_e_we,
    output logic                    tlb_other_we,
    output priv_pkg::tlb_cmd_t      tlb_cmd,
    output logic [`PRIV_XLEN-1:0]   fill_index,
    output logic [2:0]              inv_op,
    output logic [`ASID_W-1:0]      inv_asid,
    output logic [`PRIV_XLEN-1:0]   inv_vaddr,
    output logic                    l1i_en,
    output logic                    l1d_en,
    output logic                    l2_en,
    output logic [1:0]              cacop_code,
    output logic                    clear_clock_gate_require,
    output logic                    clear_clock_gate
);
    import priv_pkg::*;

    priv_state_t state, next_state;
    tlb_cmd_t tlb_cmd_next;
    logic [`PRIV_XLEN-1:0] fill_index_next;
    logic [1:0] which_cache;
    logic tlb_inv_sel;
    logic [1:0] tlb_op_sel;
    logic start, done_next, idle_next;

    // xorshift 13/17/5
    always_comb begin
        fill_index_next = fill_index ^ (fill_index << 13);
        fill_index_next = fill_index_next ^ (fill_index_next >> 17);
        fill_index_next = fill_index_next ^ (fill_index_next << 5);
    end

    always_comb begin
        next_state = state;
        case (state)
            S_INIT, S_DONE_CSR, S_DONE_ERTN, S_DONE_TLB, S_DONE_L1I, S_DONE_L1D,
            S_DONE_L2, S_DONE_IDLE: begin
                next_state = S_INIT;
                if (en_in) begin  // accepted whenever stall is low
                    case (op)
                        OP_CSR:   next_state = S_CSR;
                        OP_TLB:   next_state = S_TLB;
                        OP_CACOP: next_state = S_CACOP;
                        OP_IDLE:  next_state = S_IDLE;
                        OP_ERTN:  next_state = S_ERTN;
                        default:  next_state = S_INIT;
                    endcase
                end
            end
            S_CSR:  next_state = S_DONE_CSR;
            S_ERTN: next_state = S_DONE_ERTN;
            S_TLB: begin
                if (tlb_inv_sel) begin
                    next_state = S_INVTLB;
                end else begin
                    case (tlb_op_sel)
                        2'b10:   next_state = S_TLB_SRCH;
                        2'b11:   next_state = S_TLB_RD;
                        2'b00:   next_state = S_TLB_WR;
                        default: next_state = S_TLB_FILL;
                    endcase
                end
            end
            S_TLB_SRCH, S_TLB_RD, S_TLB_WR, S_TLB_FILL, S_INVTLB: next_state = S_DONE_TLB;
            S_CACOP: begin
                case (which_cache)
                    2'd0:    next_state = S_L1I_REQ;
                    2'd1:    next_state = S_L1D_REQ;
                    default: next_state = S_L2_REQ;
                endcase
            end
            // ready and complete may land in the same cycle
            S_L1I_REQ: if (l1i_ready) next_state = l1i_complete ? S_DONE_L1I : S_L1I_WAIT;
            S_L1D_REQ: if (l1d_ready) next_state = l1d_complete ? S_DONE_L1D : S_L1D_WAIT;
            S_L2_REQ:  if (l2_ready) next_state = l2_complete ? S_DONE_L2 : S_L2_WAIT;
            S_L1I_WAIT: if (l1i_complete) next_state = S_DONE_L1I;
            S_L1D_WAIT: if (l1d_complete) next_state = S_DONE_L1D;
            S_L2_WAIT:  if (l2_complete) next_state = S_DONE_L2;
            S_IDLE:       next_state = S_IDLE_WAIT1;
            S_IDLE_WAIT1: next_state = S_IDLE_WAIT2;
            S_IDLE_WAIT2: if (icache_idle && dcache_idle) next_state = S_IDLE_PERF;
            S_IDLE_PERF:  next_state = S_IDLE_WAIT3;
            S_IDLE_WAIT3: next_state = S_IDLE_WAIT4;
            S_IDLE_WAIT4: next_state = S_DONE_IDLE;
            default:      next_state = S_INIT;
        endcase
    end

    assign start = next_state inside {S_CSR, S_TLB, S_CACOP, S_IDLE, S_ERTN};
    assign done_next = next_state inside {S_DONE_CSR, S_DONE_ERTN, S_DONE_TLB,
                                          S_DONE_L1I, S_DONE_L1D, S_DONE_L2, S_DONE_IDLE};
    assign idle_next = next_state inside {S_IDLE, S_IDLE_WAIT1, S_IDLE_WAIT2,
                                          S_IDLE_PERF, S_IDLE_WAIT3, S_IDLE_WAIT4};

    always_comb begin
        case (next_state)
            S_TLB_SRCH: tlb_cmd_next = TLB_SRCH;
            S_TLB_RD:   tlb_cmd_next = TLB_RD;
            S_TLB_WR:   tlb_cmd_next = TLB_WR;
            S_TLB_FILL: tlb_cmd_next = TLB_FILL;
            S_INVTLB:   tlb_cmd_next = TLB_INV;
            default:    tlb_cmd_next = TLB_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= S_INIT;
            en_out <= 1'b0;
            flush <= 1'b0;
            stall <= 1'b0;
            csr_query <= 1'b0;
            restore_state <= 1'b0;
            tlb_index_we <= 1'b0;
            tlb_e_we <= 1'b0;
            tlb_other_we <= 1'b0;
            tlb_cmd <= TLB_NONE;
            fill_index <= `FILL_SEED;
            l1i_en <= 1'b0;
            l1d_en <= 1'b0;
            l2_en <= 1'b0;
            clear_clock_gate_require <= 1'b0;
            clear_clock_gate <= 1'b0;
        end else begin
            state <= next_state;
            en_out <= done_next;
            flush <= done_next;
            stall <= !(done_next || next_state == S_INIT);
            csr_query <= next_state == S_CSR;
            restore_state <= next_state == S_ERTN;
            tlb_index_we <= next_state == S_TLB_SRCH;
            tlb_e_we <= next_state == S_TLB_RD;
            tlb_other_we <= next_state == S_TLB_RD;
            tlb_cmd <= tlb_cmd_next;
            if (next_state == S_DONE_TLB)
                fill_index <= fill_index_next;
            l1i_en <= next_state == S_L1I_REQ;  // drops once ready is seen
            l1d_en <= next_state == S_L1D_REQ;
            l2_en <= next_state == S_L2_REQ;
            clear_clock_gate_require <= idle_next;
            clear_clock_gate <= next_state == S_IDLE_PERF;
        end
    end

    // operands latched as the op is accepted
    always_ff @(posedge clk) begin
        if (start) begin
            pc_target <= (op == OP_ERTN) ? era : pc_next;
            addr_out <= addr_in;
            csr_addr <= imm[13:0];
            csr_wen <= (inst[9:5] == 5'd1) ? '1 : sr0;
            csr_wdata <= sr1;
            tlb_inv_sel <= inst[16];
            tlb_op_sel <= inst[11:10];
            inv_op <= (inst[4:0] == 5'd0) ? 3'd1 : inst[2:0];
            inv_asid <= sr0[`ASID_W-1:0];
            inv_vaddr <= sr1;
            which_cache <= inst[1:0];
            cacop_code <= inst[4:3];
        end
        if (next_state == S_DONE_CSR)
            result <= csr_rdata;  // value before this edge's write
    end

endmodule

/* rtl/priv_pkg.sv */
package priv_pkg;

    typedef enum logic [2:0] {
        OP_CSR,
        OP_TLB,
        OP_CACOP,
        OP_IDLE,
        OP_ERTN
    } priv_op_t;

    // one-hot, one bit per state
    typedef enum logic [28:0] {
        S_INIT       = 29'd1 << 0,
        S_CSR        = 29'd1 << 1,
        S_CACOP      = 29'd1 << 2,
        S_TLB        = 29'd1 << 3,
        S_IDLE       = 29'd1 << 4,
        S_ERTN       = 29'd1 << 5,
        S_DONE_CSR   = 29'd1 << 6,
        S_DONE_ERTN  = 29'd1 << 7,
        S_DONE_TLB   = 29'd1 << 8,
        S_L1I_REQ    = 29'd1 << 9,
        S_L1D_REQ    = 29'd1 << 10,
        S_L2_REQ     = 29'd1 << 11,
        S_L1I_WAIT   = 29'd1 << 12,
        S_L1D_WAIT   = 29'd1 << 13,
        S_L2_WAIT    = 29'd1 << 14,
        S_DONE_L1I   = 29'd1 << 15,
        S_DONE_L1D   = 29'd1 << 16,
        S_DONE_L2    = 29'd1 << 17,
        S_TLB_SRCH   = 29'd1 << 18,
        S_TLB_RD     = 29'd1 << 19,
        S_TLB_WR     = 29'd1 << 20,
        S_TLB_FILL   = 29'd1 << 21,
        S_INVTLB     = 29'd1 << 22,
        S_DONE_IDLE  = 29'd1 << 23,
        S_IDLE_WAIT1 = 29'd1 << 24,
        S_IDLE_WAIT2 = 29'd1 << 25,
        S_IDLE_PERF  = 29'd1 << 26,
        S_IDLE_WAIT3 = 29'd1 << 27,
        S_IDLE_WAIT4 = 29'd1 << 28
    } priv_state_t;

    typedef enum logic [2:0] {
        TLB_NONE,
        TLB_SRCH,
        TLB_RD,
        TLB_WR,
        TLB_FILL,
        TLB_INV
    } tlb_cmd_t;

endpackage

/* rtl/priv_top.sv */
`include "priv_macros.svh"

module priv_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    en_in,
    input  priv_pkg::priv_op_t      op,
    input  logic [31:0]             inst,
    input  logic [`PRIV_XLEN-1:0]   sr0,
    input  logic [`PRIV_XLEN-1:0]   sr1,
    input  logic [`PRIV_XLEN-1:0]   imm,
    input  logic [`PRIV_XLEN-1:0]   pc_next,
    input  logic [4:0]              addr_in,
    output logic                    en_out,
    output logic                    flush,
    output logic                    stall,
    output logic [`PRIV_XLEN-1:0]   result,
    output logic [4:0]              addr_out,
    output logic [`PRIV_XLEN-1:0]   pc_target,
    output logic                    l1i_en,
    output logic                    l1d_en,
    output logic                    l2_en,
    output logic [1:0]              cacop_code,
    input  logic                    l1i_ready,
    input  logic                    l1d_ready,
    input  logic                    l2_ready,
    input  logic                    l1i_complete,
    input  logic                    l1d_complete,
    input  logic                    l2_complete,
    output logic                    clear_clock_gate_require,
    output logic                    clear_clock_gate,
    input  logic                    icache_idle,
    input  logic                    dcache_idle
);
    import priv_pkg::*;

    // exec to csr file
    logic csr_query, restore_state;
    logic [13:0] csr_addr;
    logic [`PRIV_XLEN-1:0] csr_wen, csr_wdata, csr_rdata, era;
    logic tlb_index_we, tlb_e_we, tlb_other_we;

    // tlb command and operands
    tlb_cmd_t tlb_cmd;
    logic [`PRIV_XLEN-1:0] fill_index, inv_vaddr;
    logic [2:0] inv_op;
    logic [`ASID_W-1:0] inv_asid, asid;

    logic [`PRIV_XLEN-1:0] tlbidx, tlbehi, tlbelo0, rd_ehi, rd_elo;
    logic srch_hit;
    logic [`TLB_IDX_W-1:0] srch_idx;

    priv_exec u_exec (.*);

    csr_file u_csr (.*);

    tlb_array u_tlb (.*);

endmodule

/* rtl/tlb_array.sv */
`include "priv_macros.svh"

module tlb_array (
    input  logic                    clk,
    input  logic                    rstn,
    input  priv_pkg::tlb_cmd_t      tlb_cmd,
    input  logic [`PRIV_XLEN-1:0]   fill_index,
    input  logic [`PRIV_XLEN-1:0]   tlbidx,
    input  logic [`PRIV_XLEN-1:0]   tlbehi,
    input  logic [`PRIV_XLEN-1:0]   tlbelo0,
    input  logic [`ASID_W-1:0]      asid,
    input  logic [2:0]              inv_op,
    input  logic [`ASID_W-1:0]      inv_asid,
    input  logic [`PRIV_XLEN-1:0]   inv_vaddr,
    output logic                    srch_hit,
    output logic [`TLB_IDX_W-1:0]   srch_idx,
    output logic [`PRIV_XLEN-1:0]   rd_ehi,
    output logic [`PRIV_XLEN-1:0]   rd_elo
);
    import priv_pkg::*;

    localparam int VPPN_W = `PRIV_XLEN - 13;

    logic [`TLB_ENTRIES-1:0] valid, g, inv_hit;
    logic [VPPN_W-1:0] vppn [`TLB_ENTRIES];
    logic [`ASID_W-1:0] e_asid [`TLB_ENTRIES];
    logic [`PRIV_XLEN-1:0] elo [`TLB_ENTRIES];
    logic [`TLB_IDX_W-1:0] wr_idx, rd_idx;
    logic wr_en;

    assign wr_en = (tlb_cmd == TLB_WR) || (tlb_cmd == TLB_FILL);
    assign wr_idx = (tlb_cmd == TLB_FILL) ? fill_index[`TLB_IDX_W-1:0]
                                          : tlbidx[`TLB_IDX_W-1:0];
    assign rd_idx = tlbidx[`TLB_IDX_W-1:0];
    assign rd_ehi = valid[rd_idx] ? {vppn[rd_idx], 13'b0} : '0;
    assign rd_elo = valid[rd_idx] ? elo[rd_idx] : '0;

    // lowest matching entry wins
    always_comb begin
        srch_hit = 1'b0;
        srch_idx = '0;
        for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
            if (valid[i] && vppn[i] == tlbehi[`PRIV_XLEN-1:13] &&
                (g[i] || e_asid[i] == asid)) begin
                srch_hit = 1'b1;
                srch_idx = i[`TLB_IDX_W-1:0];
            end
        end
    end

    always_comb begin
        logic va_m, as_m;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            va_m = vppn[i] == inv_vaddr[`PRIV_XLEN-1:13];
            as_m = e_asid[i] == inv_asid;
            case (inv_op)
                3'd0, 3'd1: inv_hit[i] = 1'b1;
                3'd2:       inv_hit[i] = g[i];
                3'd3:       inv_hit[i] = !g[i];
                3'd4:       inv_hit[i] = !g[i] && as_m;
                3'd5:       inv_hit[i] = !g[i] && as_m && va_m;
                3'd6:       inv_hit[i] = (g[i] || as_m) && va_m;
                default:    inv_hit[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn)
            valid <= '0;
        else if (wr_en)
            valid[wr_idx] <= 1'b1;
        else if (tlb_cmd == TLB_INV)
            valid <= valid & ~inv_hit;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            vppn[wr_idx] <= tlbehi[`PRIV_XLEN-1:13];
            e_asid[wr_idx] <= asid;
            g[wr_idx] <= tlbelo0[6];  // global bit of elo
            elo[wr_idx] <= tlbelo0;
        end
    end

endmodule

/* test/priv_properties.sv */
module priv_properties (
    input logic clk,
    input logic rstn,
    input logic stall,
    input logic en_out,
    input logic flush,
    input logic l1i_en,
    input logic l1d_en,
    input logic l2_en
);
    stall_in_reset: assert property (@(posedge clk) !rstn |=> !stall)
        else $error("stall high after a reset edge");

    en_out_pulse: assert property (@(posedge clk) disable iff (!rstn) en_out |=> !en_out)
        else $error("en_out longer than one cycle");

    // one cache request at a time
    one_cache_en: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0({l1i_en, l1d_en, l2_en}))
        else $error("more than one cache enable");

    flush_with_done: assert property (@(posedge clk) disable iff (!rstn) flush |-> en_out)
        else $error("flush without en_out");

endmodule

bind priv_top priv_properties props0 (
    .clk(clk), .rstn(rstn), .stall(stall), .en_out(en_out), .flush(flush),
    .l1i_en(l1i_en), .l1d_en(l1d_en), .l2_en(l2_en)
);

/* test/priv_tb.sv */
`include "priv_macros.svh"

module priv_tb;
    import priv_pkg::*;

    logic clk, rstn, en_in, en_out, flush, stall;
    priv_op_t op;
    logic [31:0] inst, sr0, sr1, imm, pc_next, result, pc_target;
    logic [4:0] addr_in, addr_out;
    logic l1i_en, l1d_en, l2_en, l1i_ready, l1d_ready, l2_ready;
    logic l1i_complete, l1d_complete, l2_complete;
    logic [1:0] cacop_code;
    logic clear_clock_gate_require, clear_clock_gate, icache_idle, dcache_idle;

    // reference model
    logic [31:0] m_csr [7];  // crmd prmd era tlbidx tlbehi tlbelo0 asid
    logic m_valid [8];
    logic m_g [8];
    logic [18:0] m_vppn [8];
    logic [9:0] m_asid [8];
    logic [31:0] m_elo [8];
    logic [31:0] m_fill;
    logic [13:0] csr_addrs [8];
    int val_errs, proto_errs;
    logic cache_done;

    tb_clock clk_gen (.clk(clk));

    priv_top dut0 (.*);

    task automatic report_mismatch(input string name, input logic [31:0] got, exp);
        $display("FAIL %s: got %h expected %h", name, got, exp);
        val_errs++;
    endtask

    task automatic report_problem(input string msg);
        $display("protocol error: %s", msg);
        proto_errs++;
    endtask

    function automatic int csr_slot(input logic [13:0] a);
        case (a)
            `CSR_CRMD:    return 0;
            `CSR_PRMD:    return 1;
            `CSR_ERA:     return 2;
            `CSR_TLBIDX:  return 3;
            `CSR_TLBEHI:  return 4;
            `CSR_TLBELO0: return 5;
            `CSR_ASID:    return 6;
            default:      return -1;
        endcase
    endfunction

    // small values so that searches hit now and then
    function automatic logic [31:0] rand_data(input logic [13:0] a);
        if (a == `CSR_TLBEHI)
            return ($urandom % 4) << 13;
        if (a == `CSR_ASID)
            return $urandom % 4;
        return $urandom;
    endfunction

    task automatic run_op(input priv_op_t o, input logic [31:0] i, s0, s1, im, input int lat);
        logic [31:0] pcn, exp_pc;
        logic [2:0] sel, exp_sel;
        int n, idle_at, raised_n, ccg_at, ccg_cnt, exp_lat;
        pcn = $urandom;
        exp_pc = (o == OP_ERTN) ? m_csr[2] : pcn;
        exp_sel = (i[1:0] == 2'd0) ? 3'b001 : (i[1:0] == 2'd1) ? 3'b010 : 3'b100;
        exp_lat = lat;
        idle_at = (o == OP_IDLE) ? $urandom % 4 : 0;
        raised_n = 0;
        ccg_at = 0;
        ccg_cnt = 0;
        n = 0;
        if (o == OP_IDLE && idle_at == 0)
            exp_lat = 7;
        if (idle_at > 0) begin
            icache_idle = 1'b0;
            dcache_idle = 1'b0;
        end
        cache_done = 1'b0;
        op = o;
        inst = i;
        sr0 = s0;
        sr1 = s1;
        imm = im;
        pc_next = pcn;
        addr_in = 5'($urandom % 32);
        en_in = 1'b1;
        do begin
            @(negedge clk);
            en_in = 1'b0;
            n++;
            if (!en_out && !stall)
                report_problem("stall low before en_out");
            if (!en_out && clear_clock_gate_require != (o == OP_IDLE))
                report_mismatch("clear_clock_gate_require", {31'b0, clear_clock_gate_require},
                                {31'b0, o == OP_IDLE});
            sel = {l2_en, l1d_en, l1i_en};
            if (sel != 3'b000 && (o != OP_CACOP || sel != exp_sel))
                report_mismatch("cache_en", {29'b0, sel}, {29'b0, exp_sel});
            if (sel != 3'b000 && cacop_code != i[4:3])
                report_mismatch("cacop_code", {30'b0, cacop_code}, {30'b0, i[4:3]});
            if (clear_clock_gate) begin
                ccg_cnt++;
                ccg_at = n;
                if (!(icache_idle && dcache_idle) || raised_n >= n)
                    report_problem("clear_clock_gate before both caches idle");
            end
            if (idle_at > 0 && n == idle_at + 3) begin
                icache_idle = 1'b1;
                dcache_idle = 1'b1;
                raised_n = n;
            end
        end while (!en_out && n < 200);
        if (!en_out) begin
            report_problem("timed out waiting for en_out");
            return;
        end
        if (stall)
            report_problem("stall still high with en_out");
        if (flush !== 1'b1)
            report_mismatch("flush", {31'b0, flush}, 32'h1);
        if (exp_lat > 0 && n != exp_lat)
            report_mismatch("en_out latency", n, exp_lat);
        if (pc_target !== exp_pc)
            report_mismatch("pc_target", pc_target, exp_pc);
        if (addr_out !== addr_in)
            report_mismatch("addr_out", {27'b0, addr_out}, {27'b0, addr_in});
        if (o == OP_CACOP && !cache_done)
            report_problem("cache op finished before complete");
        if (ccg_cnt != ((o == OP_IDLE) ? 1 : 0))
            report_mismatch("clear_clock_gate pulses", ccg_cnt, (o == OP_IDLE) ? 1 : 0);
        if (o == OP_IDLE && n - ccg_at != 3)
            report_mismatch("idle en_out delay", n - ccg_at, 3);
        if (clear_clock_gate_require)
            report_problem("clear_clock_gate_require still high with en_out");
    endtask

    task automatic csr_xchg(input logic [13:0] a, input logic full,
                            input logic [31:0] mask, wd);
        logic [31:0] old, m;
        int s;
        s = csr_slot(a);
        m = full ? 32'hffff_ffff : mask;
        old = (s < 0) ? 32'h0 : m_csr[s];
        if (s >= 0)
            m_csr[s] = (old & ~m) | (wd & m);
        run_op(OP_CSR, full ? 32'h20 : 32'h0, mask, wd, {18'b0, a}, 2);
        if (result !== old)
            report_mismatch("result", result, old);
    endtask

    task automatic csr_read(input logic [13:0] a);
        csr_xchg(a, 1'b0, 32'h0, $urandom);
    endtask

    task automatic tlb_op(input tlb_cmd_t c, input logic [2:0] iop, input logic [31:0] s0, s1);
        logic [31:0] i;
        logic hit, as_m, va_m, kill;
        int idx;
        hit = 1'b0;
        i = (c == TLB_INV) ? (32'h1_0000 | 32'(iop)) :
            (c == TLB_SRCH) ? 32'h800 : (c == TLB_RD) ? 32'hc00 :
            (c == TLB_FILL) ? 32'h400 : 32'h0;
        case (c)
            TLB_SRCH: begin
                for (int k = 7; k >= 0; k--) begin
                    if (m_valid[k] && m_vppn[k] == m_csr[4][31:13] &&
                        (m_g[k] || m_asid[k] == m_csr[6][9:0])) begin
                        hit = 1'b1;
                        idx = k;
                    end
                end
                m_csr[3][31] = !hit;
                if (hit)
                    m_csr[3][2:0] = idx[2:0];
            end
            TLB_RD: begin
                idx = 32'(m_csr[3][2:0]);
                m_csr[4] = m_valid[idx] ? {m_vppn[idx], 13'b0} : 32'h0;
                m_csr[5] = m_valid[idx] ? m_elo[idx] : 32'h0;
            end
            TLB_WR, TLB_FILL: begin
                idx = (c == TLB_FILL) ? 32'(m_fill[2:0]) : 32'(m_csr[3][2:0]);
                m_valid[idx] = 1'b1;
                m_vppn[idx] = m_csr[4][31:13];
                m_asid[idx] = m_csr[6][9:0];
                m_g[idx] = m_csr[5][6];
                m_elo[idx] = m_csr[5];
            end
            default: begin
                for (int k = 0; k < 8; k++) begin
                    as_m = m_asid[k] == s0[9:0];
                    va_m = m_vppn[k] == s1[31:13];
                    case (iop)
                        3'd2:    kill = m_g[k];
                        3'd3:    kill = !m_g[k];
                        3'd4:    kill = !m_g[k] && as_m;
                        3'd5:    kill = !m_g[k] && as_m && va_m;
                        3'd6:    kill = (m_g[k] || as_m) && va_m;
                        default: kill = 1'b1;
                    endcase
                    if (kill)
                        m_valid[k] = 1'b0;
                end
            end
        endcase
        run_op(OP_TLB, i, s0, s1, 32'h0, 3);
        m_fill = m_fill ^ (m_fill << 13);  // fill index steps after every tlb op
        m_fill = m_fill ^ (m_fill >> 17);
        m_fill = m_fill ^ (m_fill << 5);
    endtask

    // cache side, random ready and complete delays
    always begin
        int d1, d2;
        logic [2:0] req;
        @(negedge clk);
        req = {l2_en, l1d_en, l1i_en};
        if (req != 3'b000) begin
            d1 = $urandom % 6;
            d2 = $urandom % 6;
            repeat (d1) @(negedge clk);
            {l2_ready, l1d_ready, l1i_ready} = req;
            if (d2 == 0) begin
                {l2_complete, l1d_complete, l1i_complete} = req;
                cache_done = 1'b1;
            end
            @(negedge clk);
            {l2_ready, l1d_ready, l1i_ready} = 3'b000;
            if (d2 != 0) begin
                repeat (d2 - 1) @(negedge clk);
                {l2_complete, l1d_complete, l1i_complete} = req;
                cache_done = 1'b1;
                @(negedge clk);
            end
            {l2_complete, l1d_complete, l1i_complete} = 3'b000;
        end
    end

    initial begin
        #(300 * 40 * 20);
        $display("watchdog expired before the test finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        logic [13:0] a;
        void'($urandom(84718));
        csr_addrs = '{`CSR_CRMD, `CSR_PRMD, `CSR_ERA, `CSR_TLBIDX, `CSR_TLBEHI,
                      `CSR_TLBELO0, `CSR_ASID, 14'h3};
        rstn = 1'b0;
        en_in = 1'b0;
        op = OP_CSR;
        {inst, sr0, sr1, imm, pc_next} = '0;
        addr_in = '0;
        {l1i_ready, l1d_ready, l2_ready, l1i_complete, l1d_complete, l2_complete} = '0;
        icache_idle = 1'b1;
        dcache_idle = 1'b1;
        val_errs = 0;
        proto_errs = 0;
        cache_done = 1'b0;
        m_fill = `FILL_SEED;
        for (int k = 0; k < 7; k++)
            m_csr[k] = 32'h0;
        for (int k = 0; k < 8; k++)
            m_valid[k] = 1'b0;
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        for (int t = 0; t < 300; t++) begin
            case ($urandom % 7)
                0: begin
                    a = csr_addrs[$urandom % 8];
                    csr_xchg(a, 1'($urandom % 2), $urandom, rand_data(a));
                    csr_read(a);
                end
                1: begin
                    csr_xchg(`CSR_ERA, 1'b1, 32'h0, $urandom);
                    csr_xchg(`CSR_PRMD, 1'b1, 32'h0, $urandom);
                    m_csr[0][2:0] = m_csr[1][2:0];  // crmd restored from prmd
                    run_op(OP_ERTN, $urandom, 32'h0, 32'h0, 32'h0, 2);
                    csr_read(`CSR_CRMD);
                end
                2: begin
                    csr_xchg(`CSR_TLBEHI, 1'b1, 32'h0, rand_data(`CSR_TLBEHI));
                    csr_xchg(`CSR_TLBELO0, 1'b1, 32'h0, $urandom);
                    csr_xchg(`CSR_ASID, 1'b1, 32'h0, rand_data(`CSR_ASID));
                    if ($urandom % 2) begin
                        csr_xchg(`CSR_TLBIDX, 1'b1, 32'h0, $urandom);
                        tlb_op(TLB_WR, 3'd0, 32'h0, 32'h0);
                    end else begin
                        tlb_op(TLB_FILL, 3'd0, 32'h0, 32'h0);
                    end
                    tlb_op(TLB_SRCH, 3'd0, 32'h0, 32'h0);
                    csr_read(`CSR_TLBIDX);
                end
                3: begin
                    csr_xchg(`CSR_TLBEHI, 1'b1, 32'h0, rand_data(`CSR_TLBEHI));
                    csr_xchg(`CSR_ASID, 1'b1, 32'h0, rand_data(`CSR_ASID));
                    tlb_op(TLB_SRCH, 3'd0, 32'h0, 32'h0);
                    csr_read(`CSR_TLBIDX);
                    tlb_op(TLB_RD, 3'd0, 32'h0, 32'h0);
                    csr_read(`CSR_TLBEHI);
                    csr_read(`CSR_TLBELO0);
                end
                4: begin
                    tlb_op(TLB_INV, 3'($urandom % 7), $urandom % 4, ($urandom % 4) << 13);
                    csr_xchg(`CSR_TLBEHI, 1'b1, 32'h0, rand_data(`CSR_TLBEHI));
                    tlb_op(TLB_SRCH, 3'd0, 32'h0, 32'h0);
                    csr_read(`CSR_TLBIDX);
                end
                5: run_op(OP_CACOP, $urandom, 32'h0, 32'h0, 32'h0, -1);
                default: run_op(OP_IDLE, $urandom, 32'h0, 32'h0, 32'h0, -1);
            endcase
        end
        $display("errors: %0d value, %0d protocol", val_errs, proto_errs);
        if (val_errs + proto_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* test/tb_clock.sv */
module tb_clock (
    output logic clk
);
    initial clk = 1'b0;

    always #10 clk = ~clk;  // period 20

endmodule
